//--- verif/frontend_stim.txt
// First line holds word count, redirect count and instructions to consume, in hex
// Then the image from 1c000000 and one redirect per line as consumed index and target pc
16 6 46
// Straight code, then B at 1c000018 to 1c000028
02800401 02800802 02800c03 02801004
02801405 02801806 50001000 02802008
// B in word 1 at 1c000034 to 1c000044
02802409 0280280a 02802c0b 0280300c
0280340d 50001000 02803c0f 02804010
// Backward B at 1c000050 to the start, the word after it never shows up
02804411 02804812 02804c13 02805014
53ffb3ff 02805816
// Redirects
14 1c000024
1e 1c000006
1f 1c00003c
2d 1c000100
34 1c000000
3c 1c000008

//--- filelist.f
design/frontend_pkg.sv
design/fetch_pc.sv
design/predecode.sv
design/inst_buffer.sv
design/frontend_top.sv
verif/frontend_tb.sv

//--- Makefile
TOP = frontend_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- verif/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       imem_req;
    logic       imem_ack;
    addr_t      imem_addr;
    block_t     imem_data;
    logic       out1_valid, out2_valid, out1_pred_taken, out2_pred_taken;
    addr_t      out1_pc, out2_pc, out1_pred_target, out2_pred_target;
    inst_t      out1_inst, out2_inst;
    excp_t      out1_excp, out2_excp;
    logic [1:0] consume;

    // Raw stim words, then the image and redirect script taken from them
    logic [31:0] stim [0:255];
    inst_t       image [0:63];
    int          redir_idx [0:15];
    addr_t       redir_pc [0:15];
    int          word_count, redir_count, total, redir_next;

    logic [31:0] lfsr_state;
    int          errors, checks, cycles, limit, consumed, mem_wait, halt_cycles;
    logic        mem_busy, req_seen, model_halted;
    addr_t       model_pc;

    frontend_top DUT (.*);

    always begin
        #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Words outside the image read as NOP
    function automatic inst_t image_word(addr_t addr);
        addr_t offset;
        if (addr < RESET_PC) begin
            return NOP_INST;
        end
        offset = (addr - RESET_PC) >> 2;
        if (offset >= addr_t'(word_count)) begin
            return NOP_INST;
        end
        return image[offset[5:0]];
    endfunction

    task automatic load_stim();
        int i;
        int base;
        $readmemh("verif/frontend_stim.txt", stim);
        word_count  = int'(stim[0]);
        redir_count = int'(stim[1]);
        total       = int'(stim[2]);
        if (word_count > 64 || redir_count > 16 || total == 0) begin
            $display("Stimulus file is missing or malformed");
            errors++;
            total = 0;
            return;
        end
        for (i = 0; i < 64; i++) begin
            image[i] = (i < word_count) ? stim[3 + i] : NOP_INST;
        end
        base = 3 + word_count;
        for (i = 0; i < redir_count; i++) begin
            redir_idx[i] = int'(stim[base + 2 * i]);
            redir_pc[i]  = stim[base + 2 * i + 1];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Program walk: taken B goes to its target, everything else to pc + 4
    task automatic model_next(output addr_t pc, output inst_t inst, output logic taken,
                              output addr_t target, output excp_t excp);
        logic [25:0] offs;
        pc     = model_pc;
        taken  = 1'b0;
        target = '0;
        if (model_pc[1:0] != 2'b00) begin
            inst         = NOP_INST;
            excp         = EXC_ADEF;
            model_halted = 1'b1;
        end else begin
            inst     = image_word(model_pc);
            excp     = EXC_NONE;
            taken    = inst[31:26] == OPC_B;
            offs     = {inst[9:0], inst[25:10]};
            target   = model_pc + {{4{offs[25]}}, offs, 2'b00};
            model_pc = taken ? target : model_pc + 32'd4;
        end
    endtask

    task automatic compare_slot(input int slot, input addr_t got_pc, input inst_t got_inst,
                                input logic got_taken, input addr_t got_target,
                                input excp_t got_excp);
        addr_t pc;
        inst_t inst;
        logic  taken;
        addr_t target;
        excp_t excp;
        model_next(pc, inst, taken, target, excp);
        check_word($sformatf("out%0d_pc", slot), got_pc, pc);
        check_word($sformatf("out%0d_inst", slot), got_inst, inst);
        check_word($sformatf("out%0d_pred_taken", slot), {31'd0, got_taken}, {31'd0, taken});
        check_word($sformatf("out%0d_excp", slot), {30'd0, got_excp}, {30'd0, excp});
        if (taken) begin
            check_word($sformatf("out%0d_pred_target", slot), got_target, target);
        end
    endtask

    // Delay of 0 to 3 cycles, drawn when a handshake phase starts
    function automatic logic delay_elapsed();
        if (!mem_busy) begin
            mem_busy = 1'b1;
            mem_wait = int'(random_bits(2));
        end
        if (mem_wait == 0) begin
            mem_busy = 1'b0;
            return 1'b1;
        end
        mem_wait--;
        return 1'b0;
    endfunction

    // Four-phase responder, ack rises and falls after 0 to 3 cycles
    task automatic step_memory();
        checks++;
        assert (!(imem_req && !req_seen && imem_ack)) else begin
            $display("imem_req was raised while imem_ack was still high");
            errors++;
        end
        if (imem_req) begin
            checks++;
            assert (imem_addr[2:0] == 3'b000) else begin
                $display("Error: imem_addr %h is not 8-byte aligned", imem_addr);
                errors++;
            end
        end
        req_seen = imem_req;
        if (imem_ack) begin
            if (!imem_req) begin
                if (delay_elapsed()) begin
                    imem_ack = 1'b0;
                end
            end
        end else if (imem_req) begin
            if (delay_elapsed()) begin
                imem_data = {image_word(imem_addr + 32'd4), image_word(imem_addr)};
                imem_ack  = 1'b1;
            end
        end
    endtask

    task automatic step_backend();
        int avail;
        int take;
        redirect_valid = 1'b0;
        consume        = 2'd0;
        checks += 2;
        assert (!(out2_valid && !out1_valid)) else begin
            $display("Slot 2 was valid without slot 1");
            errors++;
        end
        assert (!(model_halted && out1_valid)) else begin
            $display("An entry arrived after ADEF before the next redirect");
            errors++;
        end
        // Stay halted a while after ADEF so that stray entries would show
        if (model_halted) begin
            halt_cycles++;
        end
        if (redir_next < redir_count && consumed == redir_idx[redir_next] &&
            (!model_halted || halt_cycles >= 16)) begin
            redirect_valid = 1'b1;
            redirect_pc    = redir_pc[redir_next];
            model_pc       = redir_pc[redir_next];
            model_halted   = 1'b0;
            halt_cycles    = 0;
            redir_next++;
        end else begin
            avail = out2_valid ? 2 : (out1_valid ? 1 : 0);
            take  = int'(random_bits(2));
            if (take > avail) begin
                take = avail;
            end
            if (redir_next < redir_count && take > redir_idx[redir_next] - consumed) begin
                take = redir_idx[redir_next] - consumed;
            end
            if (take > total - consumed) begin
                take = total - consumed;
            end
            if (model_halted) begin
                take = 0;
            end
            if (take >= 1) begin
                compare_slot(1, out1_pc, out1_inst, out1_pred_taken, out1_pred_target,
                             out1_excp);
            end
            if (take == 2) begin
                compare_slot(2, out2_pc, out2_inst, out2_pred_taken, out2_pred_target,
                             out2_excp);
            end
            consumed += take;
            consume   = 2'(take);
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        imem_ack       = 1'b0;
        imem_data      = '0;
        consume        = 2'd0;
        lfsr_state     = 32'hf38d;
        {errors, checks, cycles, consumed, mem_wait, redir_next, halt_cycles} = '0;
        {mem_busy, req_seen, model_halted} = '0;
        model_pc = RESET_PC;
        load_stim();
        limit = 64 * total + 500;

        repeat (8) @(negedge clk);
        check_word("out1_valid", {31'd0, out1_valid}, 32'd0);
        check_word("out2_valid", {31'd0, out2_valid}, 32'd0);
        check_word("imem_req", {31'd0, imem_req}, 32'd0);
        reset = 1'b0;

        while (consumed < total && cycles < limit) begin
            @(negedge clk);
            cycles++;
            step_memory();
            step_backend();
        end
        if (consumed < total) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions consumed",
                     cycles, consumed, total);
            errors++;
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       redirect_valid,
    input  addr_t      redirect_pc,

    output logic       imem_req,
    output addr_t      imem_addr,
    input  logic       imem_ack,
    input  block_t     imem_data,

    output logic       out1_valid,
    output logic       out2_valid,
    output addr_t      out1_pc,
    output addr_t      out2_pc,
    output addr_t      out1_pred_target,
    output addr_t      out2_pred_target,
    output inst_t      out1_inst,
    output inst_t      out2_inst,
    output logic       out1_pred_taken,
    output logic       out2_pred_taken,
    output excp_t      out1_excp,
    output excp_t      out2_excp,
    input  logic [1:0] consume
);

    logic       pred_redirect;
    addr_t      pred_target;
    logic       buf_ready;

    logic       blk_valid;
    addr_t      blk_pc;
    block_t     blk_data;
    excp_t      blk_excp;

    logic [1:0] in_size;
    addr_t      in_pc1;
    inst_t      in_inst1;
    logic       in_pred_taken1;
    addr_t      in_pred_target1;
    excp_t      in_excp1;
    addr_t      in_pc2;
    inst_t      in_inst2;
    logic       in_pred_taken2;
    addr_t      in_pred_target2;
    excp_t      in_excp2;

    fetch_pc u_fetch_pc (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_redirect  (pred_redirect),
        .pred_target    (pred_target),
        .buf_ready      (buf_ready),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_ack       (imem_ack),
        .imem_data      (imem_data),
        .blk_valid      (blk_valid),
        .blk_pc         (blk_pc),
        .blk_data       (blk_data),
        .blk_excp       (blk_excp)
    );

    predecode u_predecode (
        .blk_valid       (blk_valid),
        .blk_pc          (blk_pc),
        .blk_data        (blk_data),
        .blk_excp        (blk_excp),
        .in_size         (in_size),
        .in_pc1          (in_pc1),
        .in_inst1        (in_inst1),
        .in_pred_taken1  (in_pred_taken1),
        .in_pred_target1 (in_pred_target1),
        .in_excp1        (in_excp1),
        .in_pc2          (in_pc2),
        .in_inst2        (in_inst2),
        .in_pred_taken2  (in_pred_taken2),
        .in_pred_target2 (in_pred_target2),
        .in_excp2        (in_excp2),
        .pred_redirect   (pred_redirect),
        .pred_target     (pred_target)
    );

    // Back-end redirect also empties the queue
    inst_buffer u_inst_buffer (
        .clk              (clk),
        .reset            (reset),
        .flush            (redirect_valid),
        .in_size          (in_size),
        .in_pc1           (in_pc1),
        .in_inst1         (in_inst1),
        .in_pred_taken1   (in_pred_taken1),
        .in_pred_target1  (in_pred_target1),
        .in_excp1         (in_excp1),
        .in_pc2           (in_pc2),
        .in_inst2         (in_inst2),
        .in_pred_taken2   (in_pred_taken2),
        .in_pred_target2  (in_pred_target2),
        .in_excp2         (in_excp2),
        .buf_ready        (buf_ready),
        .out1_valid       (out1_valid),
        .out1_pc          (out1_pc),
        .out1_inst        (out1_inst),
        .out1_pred_taken  (out1_pred_taken),
        .out1_pred_target (out1_pred_target),
        .out1_excp        (out1_excp),
        .out2_valid       (out2_valid),
        .out2_pc          (out2_pc),
        .out2_inst        (out2_inst),
        .out2_pred_taken  (out2_pred_taken),
        .out2_pred_target (out2_pred_target),
        .out2_excp        (out2_excp),
        .consume          (consume)
    );

endmodule

//--- design/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import frontend_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,

    input  logic [1:0] in_size,
    input  addr_t      in_pc1,
    input  inst_t      in_inst1,
    input  logic       in_pred_taken1,
    input  addr_t      in_pred_target1,
    input  excp_t      in_excp1,
    input  addr_t      in_pc2,
    input  inst_t      in_inst2,
    input  logic       in_pred_taken2,
    input  addr_t      in_pred_target2,
    input  excp_t      in_excp2,

    output logic       buf_ready,

    output logic       out1_valid,
    output addr_t      out1_pc,
    output inst_t      out1_inst,
    output logic       out1_pred_taken,
    output addr_t      out1_pred_target,
    output excp_t      out1_excp,

    output logic       out2_valid,
    output addr_t      out2_pc,
    output inst_t      out2_inst,
    output logic       out2_pred_taken,
    output addr_t      out2_pred_target,
    output excp_t      out2_excp,

    input  logic [1:0] consume
);

    addr_t pc_q          [BUF_DEPTH];
    inst_t inst_q        [BUF_DEPTH];
    logic  pred_taken_q  [BUF_DEPTH];
    addr_t pred_target_q [BUF_DEPTH];
    excp_t excp_q        [BUF_DEPTH];

    buf_ptr_t head;
    buf_ptr_t tail;
    buf_ptr_t head_next;
    buf_ptr_t tail_next;
    buf_cnt_t count;

    // Pointers wrap at the queue depth
    assign head_next = head + 3'd1;
    assign tail_next = tail + 3'd1;

    assign buf_ready = count <= BUF_READY_LIMIT;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= 3'd0;
            tail  <= 3'd0;
            count <= 4'd0;
        end else begin
            tail  <= tail + {1'b0, in_size};
            head  <= head + {1'b0, consume};
            count <= count + {2'b00, in_size} - {2'b00, consume};
        end
    end

    always_ff @(posedge clk) begin
        if (in_size != 2'd0) begin
            pc_q[tail]          <= in_pc1;
            inst_q[tail]        <= in_inst1;
            pred_taken_q[tail]  <= in_pred_taken1;
            pred_target_q[tail] <= in_pred_target1;
            excp_q[tail]        <= in_excp1;
        end
        if (in_size == 2'd2) begin
            pc_q[tail_next]          <= in_pc2;
            inst_q[tail_next]        <= in_inst2;
            pred_taken_q[tail_next]  <= in_pred_taken2;
            pred_target_q[tail_next] <= in_pred_target2;
            excp_q[tail_next]        <= in_excp2;
        end
    end

    assign out1_valid       = count >= 4'd1;
    assign out1_pc          = pc_q[head];
    assign out1_inst        = inst_q[head];
    assign out1_pred_taken  = pred_taken_q[head];
    assign out1_pred_target = pred_target_q[head];
    assign out1_excp        = excp_q[head];

    assign out2_valid       = count >= 4'd2;
    assign out2_pc          = pc_q[head_next];
    assign out2_inst        = inst_q[head_next];
    assign out2_pred_taken  = pred_taken_q[head_next];
    assign out2_pred_target = pred_target_q[head_next];
    assign out2_excp        = excp_q[head_next];

endmodule

//--- design/predecode.sv
`timescale 1ns/1ps

module predecode import frontend_pkg::*; (
    input  logic   blk_valid,
    input  addr_t  blk_pc,
    input  block_t blk_data,
    input  excp_t  blk_excp,

    output logic [1:0] in_size,

    output addr_t  in_pc1,
    output inst_t  in_inst1,
    output logic   in_pred_taken1,
    output addr_t  in_pred_target1,
    output excp_t  in_excp1,

    output addr_t  in_pc2,
    output inst_t  in_inst2,
    output logic   in_pred_taken2,
    output addr_t  in_pred_target2,
    output excp_t  in_excp2,

    output logic   pred_redirect,
    output addr_t  pred_target
);

    function automatic logic is_b(inst_t inst);
        return inst[31:26] == OPC_B;
    endfunction

    // offs26 is {inst[9:0], inst[25:10]}, a word offset
    function automatic addr_t b_target(addr_t pc, inst_t inst);
        logic [25:0] offs26;
        offs26 = {inst[9:0], inst[25:10]};
        return pc + {{4{offs26[25]}}, offs26, 2'b00};
    endfunction

    logic  has_excp;
    logic  word1_only;
    inst_t first_inst;
    logic  dual;

    assign has_excp   = blk_excp != EXC_NONE;
    assign word1_only = blk_pc[2];
    assign first_inst = word1_only ? blk_data[63:32] : blk_data[31:0];

    // Slot 1 is either word of the block
    assign in_pc1          = blk_pc;
    assign in_inst1        = has_excp ? NOP_INST : first_inst;
    assign in_pred_taken1  = !has_excp && is_b(first_inst);
    assign in_pred_target1 = b_target(blk_pc, first_inst);
    assign in_excp1        = blk_excp;

    // Slot 2 only exists for a word-0 fetch
    assign in_pc2          = blk_pc + 32'd4;
    assign in_inst2        = blk_data[63:32];
    assign in_pred_taken2  = is_b(blk_data[63:32]);
    assign in_pred_target2 = b_target(in_pc2, blk_data[63:32]);
    assign in_excp2        = EXC_NONE;

    // Word after a taken branch is dropped
    assign dual = !has_excp && !word1_only && !in_pred_taken1;

    always_comb begin
        if (!blk_valid) begin
            in_size = 2'd0;
        end else if (dual) begin
            in_size = 2'd2;
        end else begin
            in_size = 2'd1;
        end
    end

    assign pred_redirect = blk_valid && (in_pred_taken1 || (dual && in_pred_taken2));
    assign pred_target   = in_pred_taken1 ? in_pred_target1 : in_pred_target2;

endmodule

//--- design/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc import frontend_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    input  logic   redirect_valid,
    input  addr_t  redirect_pc,
    input  logic   pred_redirect,
    input  addr_t  pred_target,
    input  logic   buf_ready,

    output logic   imem_req,
    output addr_t  imem_addr,
    input  logic   imem_ack,
    input  block_t imem_data,

    output logic   blk_valid,
    output addr_t  blk_pc,
    output block_t blk_data,
    output excp_t  blk_excp
);

    fetch_state_t state;
    addr_t        pc;
    logic         stale;
    logic         misaligned;
    addr_t        next_block_pc;

    assign misaligned    = pc[1:0] != 2'b00;
    assign next_block_pc = {blk_pc[31:3] + 29'd1, 3'b000};

    // Address is held steady by blk_pc while the request is open
    assign imem_req  = state == FETCH_REQ;
    assign imem_addr = {blk_pc[31:3], 3'b000};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            pc        <= RESET_PC;
            stale     <= 1'b0;
            blk_valid <= 1'b0;
        end else begin
            blk_valid <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (!redirect_valid && buf_ready) begin
                        if (misaligned) begin
                            // Single ADEF entry, then wait for a redirect
                            blk_valid <= 1'b1;
                            state     <= FETCH_HALT;
                        end else begin
                            state <= FETCH_REQ;
                        end
                    end
                end
                FETCH_REQ: begin
                    if (imem_ack) begin
                        state <= FETCH_RELEASE;
                        stale <= 1'b0;
                        if (!stale && !redirect_valid) begin
                            blk_valid <= 1'b1;
                            pc        <= next_block_pc;
                        end
                    end else if (redirect_valid) begin
                        stale <= 1'b1;
                    end
                end
                FETCH_RELEASE: begin
                    // Four-phase: ack must be low before the next request
                    if (!imem_ack) begin
                        state <= FETCH_IDLE;
                    end
                end
                FETCH_HALT: begin
                    if (redirect_valid) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase

            // Back-end redirect beats the predicted target
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (pred_redirect) begin
                pc <= pred_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && buf_ready) begin
            blk_pc   <= pc;
            blk_excp <= misaligned ? EXC_ADEF : EXC_NONE;
        end
        if (state == FETCH_REQ && imem_ack) begin
            blk_data <= imem_data;
        end
    end

endmodule

//--- design/frontend_pkg.sv
package frontend_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [63:0] block_t;
    typedef logic [2:0]  buf_ptr_t;
    typedef logic [3:0]  buf_cnt_t;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEF = 2'd1
    } excp_t;

    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'd0,
        FETCH_REQ     = 2'd1,
        FETCH_RELEASE = 2'd2,
        FETCH_HALT    = 2'd3
    } fetch_state_t;

    // Fetch start address after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

    // andi r0, r0, 0
    localparam inst_t NOP_INST = 32'h0340_0000;

    // Major opcode of unconditional B
    localparam logic [5:0] OPC_B = 6'b010100;

    localparam int BUF_DEPTH = 8;

    // One block in flight adds at most two entries
    localparam buf_cnt_t BUF_READY_LIMIT = 4'd6;

endpackage
